// ==== include/send_back_cfg.svh ====
// send-back configuration: lane count, beat width and buffer sizing
`ifndef SEND_BACK_CFG_SVH
`define SEND_BACK_CFG_SVH

// engine lanes feeding the send-back path
`define ENGINE_NUM 8

// bits per lane beat, narrowed from the full 512-bit lane
`define LANE_W 64

// bytes carried by one beat on the DMA data stream
`define BEAT_BYTES (`LANE_W / 8)

// beat buffer entries, power of two
`define FIFO_DEPTH 16

// free entries still left when almost-full rises
`define AFULL_MARGIN 4

// DMA command field widths
`define ADDR_W 64
`define LEN_W 32

`endif

// ==== run.sh ====
#!/bin/sh
# build the send-back testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module send_back_tb -o send_back_sim \
    && ./obj_dir/send_back_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// ==== source/control_regs.sv ====
// host control registers: decode writes into send-back settings and a start pulse
`timescale 1ns/100ps

`include "send_back_cfg.svh"

module control_regs import send_back_pkg::*; (
    input  logic        pcie_clk,
    input  logic        hbm_rstn,
    input  logic        reg_wr_en,
    input  logic [8:0]  reg_addr,
    input  logic [31:0] reg_wr_data,
    send_back_cfg_if.regs cfg
);

    // two halves of the model address
    logic [31:0] addr_lo;
    logic [31:0] addr_hi;

    assign cfg.addr_model = {addr_hi, addr_lo};

    ////////////////////
    // register write decode
    ////////////////////
    always_ff @(posedge pcie_clk) begin
        if (!hbm_rstn) begin
            addr_lo            <= '0;
            addr_hi            <= '0;
            cfg.data_length    <= '0;
            cfg.channel_choice <= '0;
            cfg.start          <= 1'b0;
        end else begin
            // start drops back by default, so it is one cycle wide
            cfg.start <= 1'b0;
            if (reg_wr_en) begin
                case (reg_addr_e'(reg_addr))
                    REG_ADDR_LO: addr_lo <= reg_wr_data;
                    REG_ADDR_HI: addr_hi <= reg_wr_data;
                    REG_LENGTH:  cfg.data_length <= reg_wr_data;
                    REG_CHANNEL: cfg.channel_choice <= reg_wr_data;
                    // only bit 0 means anything here
                    REG_START:   cfg.start <= reg_wr_data[0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////
    // host must not fire back-to-back starts, the engine sees a pulse per transfer
    a_start_pulse: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        cfg.start |=> !cfg.start
    ) else $error("start held high for two cycles");

endmodule

// ==== source/lane_select.sv ====
// engine lane select: registered mux of one lane's beats by channel choice
`timescale 1ns/100ps

`include "send_back_cfg.svh"

module lane_select (
    input  logic                                 pcie_clk,
    input  logic                                 hbm_rstn,
    input  logic [`ENGINE_NUM-1:0][`LANE_W-1:0]  lane_data,
    input  logic [`ENGINE_NUM-1:0]               lane_wr_en,
    send_back_cfg_if.lane                        cfg,
    output logic [`LANE_W-1:0]                   sel_data,
    output logic                                 sel_valid
);

    // lane index bits taken from the channel register
    localparam int SEL_W = $clog2(`ENGINE_NUM);

    logic [SEL_W-1:0] channel_r;

    // channel is quasi-static, one register stage is enough
    always_ff @(posedge pcie_clk) begin
        if (!hbm_rstn) begin
            channel_r <= '0;
            sel_valid <= 1'b0;
        end else begin
            channel_r <= cfg.channel_choice[SEL_W-1:0];
            // strobe of the picked lane only
            sel_valid <= lane_wr_en[channel_r];
        end
    end

    // payload follows the strobe, no reset
    always_ff @(posedge pcie_clk) begin
        sel_data <= lane_data[channel_r];
    end

endmodule

// ==== source/send_back_cfg_if.sv ====
// send-back settings bundle from the register block into the pipeline
`timescale 1ns/100ps

`include "send_back_cfg.svh"

interface send_back_cfg_if;

    // 64-bit destination of the result in host memory
    logic [`ADDR_W-1:0] addr_model;
    // bytes to send back
    logic [`LEN_W-1:0]  data_length;
    // full channel register, lane select uses the low bits
    logic [31:0]        channel_choice;
    // one-cycle kick, no handshake
    logic               start;

    // register block drives everything
    modport regs (
        output addr_model,
        output data_length,
        output channel_choice,
        output start
    );

    // lane mux only needs the channel
    modport lane (
        input channel_choice
    );

    // engine takes the transfer fields and the kick
    modport engine (
        input addr_model,
        input data_length,
        input start
    );

endinterface

// ==== source/send_back_engine.sv ====
// send-back engine: issues the DMA write command, then frames buffered beats
`timescale 1ns/100ps

`include "send_back_cfg.svh"

module send_back_engine import send_back_pkg::*; (
    input  logic               pcie_clk,
    input  logic               hbm_rstn,
    send_back_cfg_if.engine    cfg,
    // lane strobe, counted for the acceptance window
    input  logic               sel_valid,
    input  logic [`LANE_W-1:0] buf_data,
    input  logic               buf_valid,
    output logic               buf_pop,
    output logic               accept_en,
    output logic               dma_cmd_valid,
    input  logic               dma_cmd_ready,
    output logic [`ADDR_W-1:0] dma_cmd_address,
    output logic [`LEN_W-1:0]  dma_cmd_length,
    output logic               dma_data_valid,
    input  logic               dma_data_ready,
    output logic [`LANE_W-1:0] dma_data,
    output logic               dma_data_last
);

    // bytes to beats is a plain shift
    localparam int BEAT_SHIFT = $clog2(`BEAT_BYTES);

    engine_state_e      state;
    logic [`ADDR_W-1:0] addr_r;
    logic [`LEN_W-1:0]  len_r;
    logic [`LEN_W-1:0]  beat_total;
    logic [`LEN_W-1:0]  beats_calc;
    // beats let into the buffer this transfer
    logic [`LEN_W-1:0]  acc_cnt;
    // beats handed to DMA this transfer
    logic [`LEN_W-1:0]  sent_cnt;

    assign beats_calc = cfg.data_length >> BEAT_SHIFT;

    ////////////////////
    // DMA side
    ////////////////////
    assign dma_cmd_valid   = (state == CMD);
    assign dma_cmd_address = addr_r;
    assign dma_cmd_length  = len_r;

    assign dma_data_valid = (state == DATA) && buf_valid;
    assign dma_data       = buf_data;
    // final beat of the transfer
    assign dma_data_last  = dma_data_valid && (sent_cnt == beat_total - 1'b1);
    assign buf_pop        = dma_data_valid && dma_data_ready;

    // buffer takes beats only while busy and short of the total
    assign accept_en = (state != IDLE) && (acc_cnt < beat_total);

    ////////////////////
    // FSM and counters
    ////////////////////
    always_ff @(posedge pcie_clk) begin
        if (!hbm_rstn) begin
            state    <= IDLE;
            acc_cnt  <= '0;
            sent_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cfg.start) begin
                        state    <= CMD;
                        acc_cnt  <= '0;
                        sent_cnt <= '0;
                    end
                end
                CMD: begin
                    if (dma_cmd_valid && dma_cmd_ready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (buf_pop && dma_data_last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            // lane beats may arrive already while the command waits
            if (sel_valid && accept_en) begin
                acc_cnt <= acc_cnt + 1'b1;
            end
            if (buf_pop) begin
                sent_cnt <= sent_cnt + 1'b1;
            end
        end
    end

    // transfer fields, latched once per start
    always_ff @(posedge pcie_clk) begin
        if (state == IDLE && cfg.start) begin
            addr_r     <= cfg.addr_model;
            len_r      <= cfg.data_length;
            // short lengths still send one beat
            beat_total <= (beats_calc == '0) ? `LEN_W'(1) : beats_calc;
        end
    end

    ////////////////////
    // checks
    ////////////////////
    a_cmd_stable: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        (dma_cmd_valid && !dma_cmd_ready) |=>
            (dma_cmd_valid && $stable(dma_cmd_address) && $stable(dma_cmd_length))
    ) else $error("write command dropped or changed before ready");

    // last, once offered, goes away only through a handshake
    a_last_handshake: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        (dma_data_last && !dma_data_ready) |=> dma_data_last
    ) else $error("last beat withdrawn before ready");

endmodule

// ==== source/send_back_fifo.sv ====
// send-back beat buffer: circular store with registered almost-full toward engines
`timescale 1ns/100ps

`include "send_back_cfg.svh"

module send_back_fifo (
    input  logic               pcie_clk,
    input  logic               hbm_rstn,
    input  logic [`LANE_W-1:0] sel_data,
    input  logic               sel_valid,
    input  logic               accept_en,
    output logic [`LANE_W-1:0] buf_data,
    output logic               buf_valid,
    input  logic               buf_pop,
    output logic               almost_full
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    // occupancy at which the engines are told to hold off
    localparam logic [CNT_W-1:0] AFULL_LEVEL = CNT_W'(`FIFO_DEPTH - `AFULL_MARGIN);
    localparam logic [CNT_W-1:0] FULL_LEVEL  = CNT_W'(`FIFO_DEPTH);

    logic [`LANE_W-1:0] mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_next;
    logic               wr_en;

    // beats outside the transfer window are dropped here
    assign wr_en     = sel_valid && accept_en;
    assign buf_valid = (count != '0);
    // head of queue, visible the cycle after its write
    assign buf_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (wr_en && !buf_pop) begin
            count_next = count + 1'b1;
        end else if (!wr_en && buf_pop) begin
            count_next = count - 1'b1;
        end
    end

    ////////////////////
    // pointers and flags
    ////////////////////
    always_ff @(posedge pcie_clk) begin
        if (!hbm_rstn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (buf_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count       <= count_next;
            almost_full <= (count_next >= AFULL_LEVEL);
        end
    end

    // storage
    always_ff @(posedge pcie_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= sel_data;
        end
    end

    ////////////////////
    // checks
    ////////////////////
    // engines must honour almost_full, margin covers the mux latency
    a_no_overflow: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        wr_en |-> (count != FULL_LEVEL)
    ) else $error("beat written into full buffer");

    a_no_underflow: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        buf_pop |-> buf_valid
    ) else $error("pop from empty buffer");

endmodule

// ==== source/send_back_pkg.sv ====
// send-back package: host register map and engine state encodings
package send_back_pkg;

    ////////////////////
    // host register index, one 32-bit word per entry
    ////////////////////
    typedef enum logic [8:0] {
        REG_ADDR_LO = 9'd24,  // model address, low word
        REG_ADDR_HI = 9'd25,  // model address, high word
        REG_LENGTH  = 9'd32,  // transfer length in bytes
        REG_CHANNEL = 9'd34,  // engine lane to send back
        REG_START   = 9'd35   // bit 0 kicks one transfer
    } reg_addr_e;

    ////////////////////
    // send-back engine FSM
    ////////////////////
    typedef enum logic [1:0] {
        IDLE = 2'd0,  // waiting for start
        CMD  = 2'd1,  // write command offered to DMA
        DATA = 2'd2   // streaming beats out
    } engine_state_e;

endpackage

// ==== source/send_back_top.sv ====
// send-back top: register decode, lane select, beat buffer and DMA engine
`timescale 1ns/100ps

`include "send_back_cfg.svh"

module send_back_top (
    input  logic                                 pcie_clk,
    input  logic                                 hbm_rstn,
    // host register writes
    input  logic                                 reg_wr_en,
    input  logic [8:0]                           reg_addr,
    input  logic [31:0]                          reg_wr_data,
    // engine lanes
    input  logic [`ENGINE_NUM-1:0][`LANE_W-1:0]  lane_data,
    input  logic [`ENGINE_NUM-1:0]               lane_wr_en,
    output logic                                 almost_full,
    // DMA write command
    output logic                                 dma_cmd_valid,
    input  logic                                 dma_cmd_ready,
    output logic [`ADDR_W-1:0]                   dma_cmd_address,
    output logic [`LEN_W-1:0]                    dma_cmd_length,
    // DMA write data
    output logic                                 dma_data_valid,
    input  logic                                 dma_data_ready,
    output logic [`LANE_W-1:0]                   dma_data,
    output logic                                 dma_data_last
);

    send_back_cfg_if cfg_if ();

    logic [`LANE_W-1:0] sel_data;
    logic               sel_valid;
    logic               accept_en;
    logic [`LANE_W-1:0] buf_data;
    logic               buf_valid;
    logic               buf_pop;

    control_regs u_control_regs (
        .pcie_clk    (pcie_clk),
        .hbm_rstn    (hbm_rstn),
        .reg_wr_en   (reg_wr_en),
        .reg_addr    (reg_addr),
        .reg_wr_data (reg_wr_data),
        .cfg         (cfg_if.regs)
    );

    lane_select u_lane_select (
        .pcie_clk   (pcie_clk),
        .hbm_rstn   (hbm_rstn),
        .lane_data  (lane_data),
        .lane_wr_en (lane_wr_en),
        .cfg        (cfg_if.lane),
        .sel_data   (sel_data),
        .sel_valid  (sel_valid)
    );

    send_back_fifo u_send_back_fifo (
        .pcie_clk    (pcie_clk),
        .hbm_rstn    (hbm_rstn),
        .sel_data    (sel_data),
        .sel_valid   (sel_valid),
        .accept_en   (accept_en),
        .buf_data    (buf_data),
        .buf_valid   (buf_valid),
        .buf_pop     (buf_pop),
        .almost_full (almost_full)
    );

    send_back_engine u_send_back_engine (
        .pcie_clk        (pcie_clk),
        .hbm_rstn        (hbm_rstn),
        .cfg             (cfg_if.engine),
        .sel_valid       (sel_valid),
        .buf_data        (buf_data),
        .buf_valid       (buf_valid),
        .buf_pop         (buf_pop),
        .accept_en       (accept_en),
        .dma_cmd_valid   (dma_cmd_valid),
        .dma_cmd_ready   (dma_cmd_ready),
        .dma_cmd_address (dma_cmd_address),
        .dma_cmd_length  (dma_cmd_length),
        .dma_data_valid  (dma_data_valid),
        .dma_data_ready  (dma_data_ready),
        .dma_data        (dma_data),
        .dma_data_last   (dma_data_last)
    );

endmodule

// ==== verification/send_back_tb.sv ====
// send-back testbench: host register writes, lane beats and DMA checks by assertion
`timescale 1ns/100ps

`include "send_back_cfg.svh"

module send_back_tb import send_back_pkg::*; ();

    localparam int MAX_BEATS   = 20;
    // three transfers, each given its beats plus setup slack
    localparam int MAX_CYCLES  = 3 * (MAX_BEATS + 40);
    localparam int AFULL_LEVEL = `FIFO_DEPTH - `AFULL_MARGIN;
    localparam int SEL_W       = $clog2(`ENGINE_NUM);

    logic                                pcie_clk       = 1'b0;
    logic                                hbm_rstn       = 1'b0;
    logic                                reg_wr_en      = 1'b0;
    logic [8:0]                          reg_addr       = '0;
    logic [31:0]                         reg_wr_data    = '0;
    logic [`ENGINE_NUM-1:0][`LANE_W-1:0] lane_data      = '0;
    logic [`ENGINE_NUM-1:0]              lane_wr_en     = '0;
    logic                                dma_cmd_ready  = 1'b0;
    logic                                dma_data_ready = 1'b0;
    logic                                almost_full;
    logic                                dma_cmd_valid;
    logic [`ADDR_W-1:0]                  dma_cmd_address;
    logic [`LEN_W-1:0]                   dma_cmd_length;
    logic                                dma_data_valid;
    logic [`LANE_W-1:0]                  dma_data;
    logic                                dma_data_last;

    // expected side, written by the stimulus only
    logic [`LANE_W-1:0] exp_q [$];
    logic [`ADDR_W-1:0] exp_addr   = '0;
    logic [`LEN_W-1:0]  exp_len    = '0;
    int                 exp_beats  = 1;
    int                 sel_driven = 0;
    int                 start_cnt  = 0;
    logic               hold_ready = 1'b0;
    // observed side, written by the monitor only
    int cmd_cnt  = 0;
    int rd_idx   = 0;
    int beat_idx = 0;
    int done_cnt = 0;
    int errors   = 0;
    int cycles   = 0;

    send_back_top uut (
        .pcie_clk        (pcie_clk),
        .hbm_rstn        (hbm_rstn),
        .reg_wr_en       (reg_wr_en),
        .reg_addr        (reg_addr),
        .reg_wr_data     (reg_wr_data),
        .lane_data       (lane_data),
        .lane_wr_en      (lane_wr_en),
        .almost_full     (almost_full),
        .dma_cmd_valid   (dma_cmd_valid),
        .dma_cmd_ready   (dma_cmd_ready),
        .dma_cmd_address (dma_cmd_address),
        .dma_cmd_length  (dma_cmd_length),
        .dma_data_valid  (dma_data_valid),
        .dma_data_ready  (dma_data_ready),
        .dma_data        (dma_data),
        .dma_data_last   (dma_data_last)
    );

    always #20 pcie_clk = ~pcie_clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // beats per transfer, short lengths still move one beat
    function automatic int beats_for_length(input int length);
        int n;
        n = length / `BEAT_BYTES;
        if (n < 1) begin
            n = 1;
        end
        return n;
    endfunction

    ////////////////////
    // stimulus helpers
    ////////////////////
    task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
        @(posedge pcie_clk);
        reg_wr_en   <= 1'b1;
        reg_addr    <= addr;
        reg_wr_data <= data;
        @(posedge pcie_clk);
        reg_wr_en   <= 1'b0;
    endtask

    // one cycle of lane traffic, noise on the other lanes
    task automatic lane_cycle(input logic [SEL_W-1:0] lane, input bit want, input bit keep);
        logic [`ENGINE_NUM-1:0][`LANE_W-1:0] beats;
        logic [`ENGINE_NUM-1:0]              strobes;
        logic [31:0]                         rnd;
        bit                                  put;
        for (int i = 0; i < `ENGINE_NUM; i++) begin
            beats[i] = {$urandom, $urandom};
        end
        rnd = $urandom;
        strobes = rnd[`ENGINE_NUM-1:0];
        @(posedge pcie_clk);
        // engines hold off while the buffer is nearly full
        put = want && !almost_full;
        strobes[lane] = put;
        lane_data  <= beats;
        lane_wr_en <= strobes;
        if (put && keep) begin
            exp_q.push_back(beats[lane]);
            sel_driven++;
        end
    endtask

    task automatic quiet_lanes();
        @(posedge pcie_clk);
        lane_wr_en <= '0;
    endtask

    task automatic run_transfer(input logic [SEL_W-1:0] lane, input int length, input bit hold);
        exp_addr   = {$urandom, $urandom};
        exp_len    = length;
        exp_beats  = beats_for_length(length);
        sel_driven = 0;
        hold_ready <= hold;
        write_reg(REG_ADDR_LO, exp_addr[31:0]);
        write_reg(REG_ADDR_HI, exp_addr[63:32]);
        write_reg(REG_LENGTH, exp_len);
        write_reg(REG_CHANNEL, 32'(lane));
        // chosen lane while idle, buffer has to drop these
        repeat (3) lane_cycle(lane, 1'b1, 1'b0);
        quiet_lanes();
        write_reg(REG_START, 32'h1);
        start_cnt++;
        while (!dma_cmd_valid) @(posedge pcie_clk);
        if (hold) begin
            // no pops yet, fill until almost_full pushes back
            while (sel_driven < exp_beats && !almost_full) lane_cycle(lane, 1'b1, 1'b1);
            repeat (6) lane_cycle(lane, 1'b0, 1'b0);
            hold_ready <= 1'b0;
        end
        while (sel_driven < exp_beats) lane_cycle(lane, 1'b1, 1'b1);
        quiet_lanes();
        while (done_cnt < start_cnt) @(posedge pcie_clk);
    endtask

    // DMA side ready gaps
    always @(posedge pcie_clk) begin
        dma_cmd_ready  <= ($urandom % 2) == 0;
        dma_data_ready <= hold_ready ? 1'b0 : (($urandom % 4) != 0);
    end

    ////////////////////
    // monitor
    ////////////////////
    always @(posedge pcie_clk) begin
        if (hbm_rstn) begin
            if (dma_cmd_valid && dma_cmd_ready) begin
                assert (cmd_cnt < start_cnt) else flag_error("write command without a start");
                cmd_cnt++;
            end
            if (dma_data_valid && dma_data_ready) begin
                assert (rd_idx < exp_q.size())
                    else flag_error("data beat with no lane beat behind it");
                if (rd_idx < exp_q.size()) begin
                    assert (dma_data == exp_q[rd_idx])
                        else flag_error($sformatf("beat %0d is %h, lane wrote %h",
                                                  rd_idx, dma_data, exp_q[rd_idx]));
                end
                assert (dma_data_last == (beat_idx == exp_beats - 1))
                    else flag_error($sformatf("last is %b on beat %0d of %0d",
                                              dma_data_last, beat_idx, exp_beats));
                rd_idx++;
                if (dma_data_last) begin
                    // every accepted lane beat went out
                    assert (rd_idx == exp_q.size())
                        else flag_error($sformatf("%0d beats out, %0d written",
                                                  rd_idx, exp_q.size()));
                    beat_idx = 0;
                    done_cnt++;
                end else begin
                    beat_idx++;
                end
            end
        end
    end

    ////////////////////
    // protocol properties
    ////////////////////
    quiet_before_start: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        (start_cnt == 0) |-> !(dma_cmd_valid || dma_data_valid || dma_data_last || almost_full)
    ) else flag_error("DMA or almost_full active before the first start");

    cmd_matches_regs: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        (dma_cmd_valid && dma_cmd_ready) |->
            (dma_cmd_address == exp_addr && dma_cmd_length == exp_len)
    ) else flag_error("command address or length differs from the registers");

    // no data ahead of its command
    data_after_cmd: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        dma_data_valid |-> (cmd_cnt == start_cnt)
    ) else flag_error("data beat before its write command");

    last_with_valid: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        dma_data_last |-> dma_data_valid
    ) else flag_error("last without valid");

    // two cycles from lane strobe to buffer entry
    afull_at_level: assert property (
        @(posedge pcie_clk) disable iff (!hbm_rstn)
        (hold_ready && $past(sel_driven, 2) >= AFULL_LEVEL) |-> almost_full
    ) else flag_error("almost_full low with the buffer at its margin");

    always @(posedge pcie_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'ha32c));
        repeat (2) @(posedge pcie_clk);
        hbm_rstn <= 1'b1;
        run_transfer(3'd3, 64, 1'b0);
        run_transfer(3'd6, 5, 1'b0);
        run_transfer(3'd1, 8 * MAX_BEATS, 1'b1);
        repeat (4) @(posedge pcie_clk);
        $display("checks failed: %0d, beats checked: %0d, commands: %0d",
                 errors, rd_idx, cmd_cnt);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/send_back_pkg.sv
source/send_back_cfg_if.sv
source/control_regs.sv
source/lane_select.sv
source/send_back_fifo.sv
source/send_back_engine.sv
source/send_back_top.sv
verification/send_back_tb.sv
